// File: logic/qspi_pkg.sv
// ####################
// qspi package
// widths, command codes and sequencer state encoding.
// ####################
`default_nettype none

package qspi_pkg;

  localparam int num_cs = 3;  // chip selects on the bus.
  localparam int addr_w = 23;  // 8M words of 32 bits.
  localparam int data_w = 32;

  // spi command codes.
  localparam logic [7:0] cmd_read = 8'h03;
  localparam logic [7:0] cmd_write = 8'h02;
  localparam logic [7:0] cmd_quad_read = 8'hEB;  // fast read quad.
  localparam logic [7:0] cmd_quad_write = 8'h38;

  // remaining shift bits, up to one full word.
  typedef logic [5:0] bit_count_t;

  localparam bit_count_t addr_bits = 6'd24;
  localparam bit_count_t cmd_bits = 6'd8;
  localparam bit_count_t dummy_clocks = 6'd6;  // single-bit clocks.

  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_select     = 3'd1,
    st_command    = 3'd2,
    st_address    = 3'd3,
    st_dummy      = 3'd4,
    st_data_setup = 3'd5,
    st_finish     = 3'd6
  } seq_state_t;

endpackage

`default_nettype wire

// File: logic/qspi_write_align.sv
// ####################
// qspi write align
// byte offset, bit count and left-justified write word from strobes.
// ####################
`default_nettype none

module qspi_write_align
  import qspi_pkg::*;
(
  input  logic [3:0]        wstrb_i,
  input  logic [data_w-1:0] wdata_i,
  output logic [1:0]        byte_offset_o,
  output bit_count_t        wr_bits_o,
  output logic [data_w-1:0] wr_word_o
);

  always_comb begin
    wr_word_o = wdata_i;  // lower bits are don't care for short writes.
    case (wstrb_i)
      4'b0001: begin
        byte_offset_o = 2'd3;
        wr_bits_o = 6'd8;
        wr_word_o[31:24] = wdata_i[7:0];
      end
      4'b0010: begin
        byte_offset_o = 2'd2;
        wr_bits_o = 6'd8;
        wr_word_o[31:24] = wdata_i[15:8];
      end
      4'b0100: begin
        byte_offset_o = 2'd1;
        wr_bits_o = 6'd8;
        wr_word_o[31:24] = wdata_i[23:16];
      end
      4'b1000: begin
        byte_offset_o = 2'd0;
        wr_bits_o = 6'd8;
        wr_word_o[31:24] = wdata_i[31:24];
      end
      4'b0011: begin
        byte_offset_o = 2'd2;  // lower half.
        wr_bits_o = 6'd16;
        wr_word_o[31:16] = wdata_i[15:0];
      end
      4'b1100: begin
        byte_offset_o = 2'd0;  // upper half.
        wr_bits_o = 6'd16;
        wr_word_o[31:16] = wdata_i[31:16];
      end
      default: begin
        // full word, also for irregular strobe patterns
        byte_offset_o = 2'd0;
        wr_bits_o = 6'd32;
        wr_word_o = wdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/qspi_sequencer.sv
// ####################
// qspi sequencer
// command, address, dummy and data phases on the spi pins.
// ####################
`default_nettype none

module qspi_sequencer
  import qspi_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid_i,
  input  logic              busy_i,
  input  logic [addr_w-1:0] addr_i,
  input  logic [3:0]        wstrb_i,
  input  logic              psram_flash_i,
  input  logic              quad_mode_i,
  input  logic [num_cs-1:0] ce_ctrl_i,
  input  logic [1:0]        byte_offset_i,
  input  bit_count_t        wr_bits_i,
  input  logic [data_w-1:0] wr_word_i,
  input  logic [3:0]        sio_i,
  output logic              sclk_o,
  output logic [3:0]        sio_o,
  output logic [3:0]        sio_oe_o,
  output logic [num_cs-1:0] ce_o,
  output logic [data_w-1:0] rx_word_o,
  output logic              done_o
);

  seq_state_t state_q, state_d;
  logic [data_w-1:0] buf_q, buf_d;
  bit_count_t bits_q, bits_d;
  logic quad_q, quad_d;
  logic sclk_q, sclk_d;
  logic [3:0] sio_out_q, sio_out_d;
  logic [3:0] sio_oe_q, sio_oe_d;
  logic [num_cs-1:0] ce_q, ce_d;
  logic [3:0] lane_d;
  logic is_write;
  logic [1:0] addr_offset;

  assign is_write = |wstrb_i;
  assign addr_offset = is_write ? byte_offset_i : 2'b00;  // reads fetch whole words.

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= st_idle;
      buf_q <= '0;
      bits_q <= '0;
      quad_q <= 1'b0;
      sclk_q <= 1'b0;
      sio_out_q <= 4'b0000;
      sio_oe_q <= 4'b0000;
      ce_q <= '1;
    end else begin
      state_q <= state_d;
      buf_q <= buf_d;
      bits_q <= bits_d;
      quad_q <= quad_d;
      sclk_q <= sclk_d;
      sio_out_q <= sio_out_d;
      sio_oe_q <= sio_oe_d;
      ce_q <= ce_d;
    end
  end

  always_comb begin
    state_d = state_q;
    buf_d = buf_q;
    bits_d = bits_q;
    quad_d = quad_q;
    sclk_d = sclk_q;
    sio_oe_d = sio_oe_q;
    ce_d = ce_q;
    done_o = 1'b0;

    if (sclk_q) begin
      sclk_d = 1'b0;  // falling half puts the next bit out below.
    end else if (|bits_q) begin
      // rising half samples the input lines
      sclk_d = 1'b1;
      buf_d = quad_q ? {buf_q[27:0], sio_i} : {buf_q[30:0], sio_i[1]};
      bits_d = quad_q ? bits_q - 6'd4 : bits_q - 6'd1;
    end else begin
      case (state_q)
        st_idle: begin
          ce_d = '1;
          sio_oe_d = 4'b0000;
          quad_d = 1'b0;
          if (valid_i && !busy_i) begin
            state_d = st_select;
          end
        end

        st_select: begin
          ce_d = ~ce_ctrl_i;  // chip selects are active low.
          sio_oe_d = 4'b0001;
          state_d = st_command;
        end

        st_command: begin
          if (quad_mode_i) begin
            buf_d[31:24] = is_write ? cmd_quad_write : cmd_quad_read;
          end else begin
            buf_d[31:24] = is_write ? cmd_write : cmd_read;
          end
          bits_d = cmd_bits;  // always single-bit.
          state_d = st_address;
        end

        st_address: begin
          if (psram_flash_i) begin
            buf_d[31:8] = {1'b0, addr_i[20:0], addr_offset};
          end else begin
            buf_d[31:8] = {addr_i[21:0], addr_offset};
          end
          bits_d = addr_bits;
          sio_oe_d = quad_mode_i ? 4'b1111 : 4'b0001;
          quad_d = quad_mode_i;
          state_d = (quad_mode_i && !is_write) ? st_dummy : st_data_setup;
        end

        st_dummy: begin
          sio_oe_d = 4'b0000;  // lines released for turnaround.
          bits_d = dummy_clocks;
          quad_d = 1'b0;
          state_d = st_data_setup;
        end

        st_data_setup: begin
          quad_d = quad_mode_i;
          if (is_write) begin
            sio_oe_d = quad_mode_i ? 4'b1111 : 4'b0001;
            buf_d = wr_word_i;
            bits_d = wr_bits_i;
          end else begin
            sio_oe_d = quad_mode_i ? 4'b0000 : 4'b0001;
            bits_d = bit_count_t'(data_w);
          end
          state_d = st_finish;
        end

        st_finish: begin
          done_o = 1'b1;
          ce_d = '1;
          sio_oe_d = 4'b0000;
          state_d = st_idle;
        end

        default: state_d = st_idle;
      endcase
    end

    // outputs only move while the spi clock stays low
    lane_d = quad_d ? buf_d[31:28] : {3'b000, buf_d[31]};
    sio_out_d = sclk_d ? sio_out_q : (lane_d & sio_oe_d);
  end

  assign sclk_o = sclk_q;
  assign sio_o = sio_out_q;
  assign sio_oe_o = sio_oe_q;
  assign ce_o = ce_q;
  assign rx_word_o = buf_q;

endmodule

`default_nettype wire

// File: logic/qspi_read_return.sv
// ####################
// qspi read return
// orders read data and holds ready against valid.
// ####################
`default_nettype none

module qspi_read_return
  import qspi_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid_i,
  input  logic              done_i,
  input  logic [data_w-1:0] rx_word_i,
  input  logic              psram_flash_i,
  output logic [data_w-1:0] rdata_o,
  output logic              ready_o,
  output logic              busy_o
);

  logic ready_q;
  logic [data_w-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else if (done_i) begin
      ready_q <= 1'b1;
    end else if (!valid_i) begin
      ready_q <= 1'b0;  // request withdrawn.
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) begin
      if (psram_flash_i) begin
        rdata_q <= rx_word_i;  // shift order as received.
      end else begin
        // flash returns bytes in little endian order
        rdata_q <= {rx_word_i[7:0], rx_word_i[15:8], rx_word_i[23:16], rx_word_i[31:24]};
      end
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;
  assign busy_o = ready_q;  // blocks a restart until valid drops.

endmodule

`default_nettype wire

// File: logic/qspi_mem_ctrl.sv
// ####################
// qspi memory controller
// cpu word port to psram or nor flash over spi or qspi.
// ####################
`default_nettype none

module qspi_mem_ctrl
  import qspi_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  logic [addr_w-1:0] addr_i,
  input  logic [data_w-1:0] wdata_i,
  input  logic [3:0]        wstrb_i,
  input  logic              valid_i,
  input  logic              psram_flash_i,
  input  logic              quad_mode_i,
  input  logic [num_cs-1:0] ce_ctrl_i,
  input  logic [3:0]        sio_i,
  output logic [data_w-1:0] rdata_o,
  output logic              ready_o,
  output logic              sclk_o,
  output logic [3:0]        sio_o,
  output logic [3:0]        sio_oe_o,
  output logic [num_cs-1:0] ce_o
);

  logic [1:0] byte_offset;
  bit_count_t wr_bits;
  logic [data_w-1:0] wr_word;
  logic [data_w-1:0] rx_word;
  logic done;
  logic busy;

  qspi_write_align write_align_i (
    .wstrb_i       (wstrb_i),
    .wdata_i       (wdata_i),
    .byte_offset_o (byte_offset),
    .wr_bits_o     (wr_bits),
    .wr_word_o     (wr_word)
  );

  qspi_sequencer sequencer_i (
    .clk           (clk),
    .resetn        (resetn),
    .valid_i       (valid_i),
    .busy_i        (busy),
    .addr_i        (addr_i),
    .wstrb_i       (wstrb_i),
    .psram_flash_i (psram_flash_i),
    .quad_mode_i   (quad_mode_i),
    .ce_ctrl_i     (ce_ctrl_i),
    .byte_offset_i (byte_offset),
    .wr_bits_i     (wr_bits),
    .wr_word_i     (wr_word),
    .sio_i         (sio_i),
    .sclk_o        (sclk_o),
    .sio_o         (sio_o),
    .sio_oe_o      (sio_oe_o),
    .ce_o          (ce_o),
    .rx_word_o     (rx_word),
    .done_o        (done)
  );

  qspi_read_return read_return_i (
    .clk           (clk),
    .resetn        (resetn),
    .valid_i       (valid_i),
    .done_i        (done),
    .rx_word_i     (rx_word),
    .psram_flash_i (psram_flash_i),
    .rdata_o       (rdata_o),
    .ready_o       (ready_o),
    .busy_o        (busy)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// ####################
// testbench clock and reset.
// ####################
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  initial begin
    resetn = 1'b0;
    repeat (2) @(negedge clk);  // two rising edges in reset.
    resetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/qspi_mem_model.sv
// ####################
// serial memory model
// decodes spi/qspi commands on one chip select and serves bytes.
// ####################
`default_nettype none

module qspi_mem_model
  import qspi_pkg::*;
(
  input  logic       sclk_i,
  input  logic       ce_n_i,
  input  logic [3:0] ctrl_sio_i,
  output logic [3:0] sio_o
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {ph_cmd, ph_addr, ph_dummy, ph_write, ph_read, ph_skip} phase_t;

  logic [7:0] mem [int];
  phase_t phase = ph_cmd;
  logic [7:0] cmd;
  logic [23:0] addr;
  logic [7:0] shreg;
  logic quad;
  int bits = 0;
  int rd_idx = 0;
  logic [3:0] drive_en = 4'b0000;
  logic [3:0] drive_val = 4'b0000;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // top byte of the mixed state depends on every address bit
  function automatic logic [7:0] preload_byte(input logic [23:0] a);
    logic [31:0] s;
    s = lcg_next(lcg_next(32'h5f136882 ^ {8'h00, a}));
    return s[31:24];
  endfunction

  function automatic logic [7:0] read_byte(input logic [23:0] a);
    if (mem.exists(int'(a))) begin
      return mem[int'(a)];
    end
    return preload_byte(a);
  endfunction

  always @(posedge sclk_i or negedge sclk_i or posedge ce_n_i) begin
    if (ce_n_i) begin
      phase = ph_cmd;  // deselect ends the command.
      bits = 0;
      rd_idx = 0;
      drive_en = 4'b0000;
    end else if (sclk_i) begin
      case (phase)
        ph_cmd: begin
          cmd = {cmd[6:0], ctrl_sio_i[0]};
          bits++;
          if (bits == 8) begin
            quad = (cmd == cmd_quad_read) || (cmd == cmd_quad_write);
            bits = 0;
            phase = ph_addr;
          end
        end
        ph_addr: begin
          addr = quad ? {addr[19:0], ctrl_sio_i} : {addr[22:0], ctrl_sio_i[0]};
          bits += quad ? 4 : 1;
          if (bits == 24) begin
            bits = 0;
            case (cmd)
              cmd_quad_read: phase = ph_dummy;
              cmd_read: phase = ph_read;
              cmd_write, cmd_quad_write: phase = ph_write;
              default: phase = ph_skip;
            endcase
          end
        end
        ph_dummy: begin
          bits++;
          if (bits == dummy_clocks) begin
            bits = 0;
            phase = ph_read;
          end
        end
        ph_write: begin
          shreg = quad ? {shreg[3:0], ctrl_sio_i} : {shreg[6:0], ctrl_sio_i[0]};
          bits += quad ? 4 : 1;
          if (bits == 8) begin
            mem[int'(addr)] = shreg;
            addr++;
            bits = 0;
          end
        end
        default: ;
      endcase
    end else if (phase == ph_read) begin
      if (bits == 0) begin
        shreg = read_byte(addr + 24'(rd_idx));  // next byte in sequence.
        rd_idx++;
        bits = 8;
      end
      if (quad) begin
        drive_en = 4'b1111;
        drive_val = shreg[7:4];
        shreg = shreg << 4;
        bits -= 4;
      end else begin
        drive_en = 4'b0010;  // single mode returns on line 1.
        drive_val = {2'b00, shreg[7], 1'b0};
        shreg = shreg << 1;
        bits -= 1;
      end
    end
  end

  assign sio_o = (drive_val & drive_en) | (ctrl_sio_i & ~drive_en);

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
// ####################
// testbench checker
// compares read data, chip selects and ready against a shadow memory.
// ####################
`default_nettype none

module tb_checker
  import qspi_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid_i,
  input  logic              ready_i,
  input  logic [data_w-1:0] rdata_i,
  input  logic [addr_w-1:0] addr_i,
  input  logic [data_w-1:0] wdata_i,
  input  logic [3:0]        wstrb_i,
  input  logic              psram_flash_i,
  input  logic [num_cs-1:0] ce_ctrl_i,
  input  logic [num_cs-1:0] ce_i,
  input  logic              sclk_i,
  input  logic [3:0]        sio_oe_i,
  input  logic              check_read_i,
  output int                errors_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] shadow [int];
  int errors = 0;
  logic resetn_q = 1'b0;
  logic ready_q = 1'b0;
  logic valid_q = 1'b0;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] preload_byte(input logic [23:0] a);
    logic [31:0] s;
    s = lcg_next(lcg_next(32'h5f136882 ^ {8'h00, a}));
    return s[31:24];
  endfunction

  function automatic logic [7:0] stored_byte(input logic [23:0] a);
    if (shadow.exists(int'(a))) begin
      return shadow[int'(a)];
    end
    return preload_byte(a);
  endfunction

  // byte address of the word in the device layout
  function automatic logic [23:0] word_base(input logic [addr_w-1:0] a, input logic psram);
    return psram ? {1'b0, a[20:0], 2'b00} : {a[21:0], 2'b00};
  endfunction

  always @(posedge clk) begin
    logic [23:0] base;
    logic [3:0] strb;
    logic [data_w-1:0] expected;
    if (resetn && !resetn_q) begin
      if (ce_i !== '1 || ready_i !== 1'b0 || sio_oe_i !== 4'b0000 || sclk_i !== 1'b0) begin
        errors++;
        $display("Mismatch at %0t: reset state ce %b ready %b sio_oe %b sclk %b",
                 $time, ce_i, ready_i, sio_oe_i, sclk_i);
      end
    end
    if (resetn && ce_i !== '1 && ce_i !== ~ce_ctrl_i) begin
      errors++;
      $display("Mismatch at %0t: ce_o %b with ce_ctrl %b", $time, ce_i, ce_ctrl_i);
    end
    if (resetn_q && ready_q && valid_q && !ready_i) begin
      errors++;
      $display("Mismatch at %0t: ready_o fell while valid_i was held", $time);
    end
    if (resetn_q && ready_q && !valid_q && ready_i) begin
      errors++;
      $display("Mismatch at %0t: ready_o stayed high after valid_i fell", $time);
    end
    if (resetn && ready_i && !ready_q && ce_ctrl_i == num_cs'(1)) begin
      base = word_base(addr_i, psram_flash_i);
      if (|wstrb_i) begin
        case (wstrb_i)
          4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: strb = wstrb_i;
          default: strb = 4'b1111;  // odd patterns write the word.
        endcase
        for (int k = 0; k < 4; k++) begin
          if (strb[k]) begin
            shadow[int'(base + 24'(3 - k))] = wdata_i[8*k +: 8];
          end
        end
      end else if (check_read_i) begin
        for (int k = 0; k < 4; k++) begin
          expected[8*k +: 8] = psram_flash_i ? stored_byte(base + 24'(3 - k))
                                             : stored_byte(base + 24'(k));
        end
        if (rdata_i !== expected) begin
          errors++;
          $display("Mismatch at %0t: read addr %h psram %b got %h expected %h",
                   $time, addr_i, psram_flash_i, rdata_i, expected);
        end
      end
    end
    resetn_q = resetn;
    ready_q = ready_i;
    valid_q = valid_i;
  end

  assign errors_o = errors;

endmodule

`default_nettype wire

// File: verification/qspi_mem_ctrl_asserts.sv
// ####################
// pin and ready assertions for the controller.
// ####################
`default_nettype none

module qspi_mem_ctrl_asserts
  import qspi_pkg::*;
(
  input logic              clk,
  input logic              resetn,
  input logic              sclk_i,
  input logic [3:0]        sio_oe_i,
  input logic [num_cs-1:0] ce_i,
  input logic              ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic ready_q;
  logic ce_seen;  // a chip select went low since the last ready rise.
  int fail_count = 0;  // count of failed assertions.

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      ce_seen <= 1'b0;
    end else begin
      ready_q <= ready_i;
      if (ready_i && !ready_q) begin
        ce_seen <= 1'b0;
      end else if (ce_i != '1) begin
        ce_seen <= 1'b1;
      end
    end
  end

  oe_stable_a: assert property (@(posedge clk) disable iff (!resetn)
    sclk_i |=> $stable(sio_oe_i))
    else begin
      $error("sio_oe_o changed while sclk_o was high");
      fail_count++;
    end

  one_ce_a: assert property (@(posedge clk) disable iff (!resetn) $onehot0(~ce_i))
    else begin
      $error("more than one chip select low");
      fail_count++;
    end

  ready_cause_a: assert property (@(posedge clk) disable iff (!resetn)
    (ready_i && !ready_q) |-> ce_seen)
    else begin
      $error("ready_o rose without a chip select cycle");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verification/tb_qspi_mem_ctrl.sv
// ####################
// qspi memory controller testbench
// runs a request table through the dut against a serial memory model.
// ####################
`default_nettype none

module tb_qspi_mem_ctrl
  import qspi_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 400;

  typedef struct packed {
    logic              psram;
    logic              quad;
    logic [num_cs-1:0] ce;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [3:0]        wstrb;
    logic              chk;
  } row_t;

  logic clk, resetn;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata, rdata;
  logic [3:0] wstrb, sio_in, sio_out, sio_oe;
  logic valid, ready, psram_flash, quad_mode, sclk, check_read;
  logic [num_cs-1:0] ce_ctrl, ce;
  int mismatches;
  int timeouts = 0;
  logic [31:0] rng = 32'h5f136882;
  row_t rows[$];

  tb_clock_gen clock_gen_i (.clk(clk), .resetn(resetn));

  qspi_mem_ctrl qspi_mem_ctrl_i (
    .clk(clk), .resetn(resetn), .addr_i(addr), .wdata_i(wdata), .wstrb_i(wstrb),
    .valid_i(valid), .psram_flash_i(psram_flash), .quad_mode_i(quad_mode),
    .ce_ctrl_i(ce_ctrl), .sio_i(sio_in), .rdata_o(rdata), .ready_o(ready),
    .sclk_o(sclk), .sio_o(sio_out), .sio_oe_o(sio_oe), .ce_o(ce)
  );

  qspi_mem_model mem_model_i (
    .sclk_i(sclk), .ce_n_i(ce[0]), .ctrl_sio_i(sio_out), .sio_o(sio_in)
  );

  tb_checker checker_i (
    .clk(clk), .resetn(resetn), .valid_i(valid), .ready_i(ready), .rdata_i(rdata),
    .addr_i(addr), .wdata_i(wdata), .wstrb_i(wstrb), .psram_flash_i(psram_flash),
    .ce_ctrl_i(ce_ctrl), .ce_i(ce), .sclk_i(sclk), .sio_oe_i(sio_oe),
    .check_read_i(check_read), .errors_o(mismatches)
  );

  bind qspi_mem_ctrl qspi_mem_ctrl_asserts asserts_i (
    .clk(clk), .resetn(resetn), .sclk_i(sclk_o), .sio_oe_i(sio_oe_o),
    .ce_i(ce_o), .ready_i(ready_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [3:0] strobe_pattern(input int idx);
    case (idx)
      0: return 4'b0001;
      1: return 4'b0010;
      2: return 4'b0100;
      3: return 4'b1000;
      4: return 4'b0011;
      5: return 4'b1100;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic add_row(input logic psram, input logic quad, input logic [num_cs-1:0] cs,
                         input logic [addr_w-1:0] a, input logic [3:0] strb, input logic chk);
    row_t r;
    rng = lcg_next(rng);
    r = {psram, quad, cs, a, rng, strb, chk};
    rows.push_back(r);
  endtask

  task automatic wait_ready(input logic level);
    int cycles;
    cycles = 0;
    while (ready !== level && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (ready !== level) begin
      timeouts++;
      $display("Timeout at %0t: ready_o did not go to %0b in %0d cycles",
               $time, level, timeout_cycles);
    end
  endtask

  initial begin
    row_t r;
    int cycles;
    addr = '0;
    wdata = '0;
    wstrb = 4'b0000;
    valid = 1'b0;
    psram_flash = 1'b1;
    quad_mode = 1'b0;
    ce_ctrl = num_cs'(1);
    check_read = 1'b0;

    // single then quad write/read pairs over every legal strobe
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 7; i++) begin
        add_row(1'b1, m[0], 3'b001, 23'h000100 + 23'(i), strobe_pattern(i), 1'b0);
        add_row(1'b1, m[0], 3'b001, 23'h000100 + 23'(i), 4'b0000, 1'b1);
      end
    end
    add_row(1'b1, 1'b1, 3'b001, 23'h000200, 4'b0000, 1'b1);
    add_row(1'b1, 1'b0, 3'b001, 23'h000200, 4'b0000, 1'b1);
    add_row(1'b0, 1'b0, 3'b001, 23'h000100, 4'b0000, 1'b1);  // written word in flash order.
    add_row(1'b0, 1'b0, 3'b001, 23'h012345, 4'b0000, 1'b1);
    add_row(1'b0, 1'b1, 3'b001, 23'h3abcde, 4'b0000, 1'b1);
    add_row(1'b1, 1'b0, 3'b010, 23'h000300, 4'b1111, 1'b0);
    add_row(1'b1, 1'b1, 3'b100, 23'h000300, 4'b0000, 1'b0);

    cycles = 0;
    while (resetn !== 1'b1 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (resetn !== 1'b1) begin
      timeouts++;
      $display("Timeout: resetn was never released");
    end

    for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
      r = rows[i];
      @(negedge clk);
      psram_flash = r.psram;
      quad_mode = r.quad;
      ce_ctrl = r.ce;
      addr = r.addr;
      wdata = r.wdata;
      wstrb = r.wstrb;
      check_read = r.chk;
      valid = 1'b1;
      wait_ready(1'b1);
      if (timeouts == 0) begin
        @(negedge clk);  // valid held one more cycle with ready up.
        valid = 1'b0;
        wait_ready(1'b0);
      end
    end

    repeat (2) @(negedge clk);
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, qspi_mem_ctrl_i.asserts_i.fail_count);
    if (mismatches == 0 && timeouts == 0 && qspi_mem_ctrl_i.asserts_i.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: qspi_mem_ctrl.f
logic/qspi_pkg.sv
logic/qspi_write_align.sv
logic/qspi_sequencer.sv
logic/qspi_read_return.sv
logic/qspi_mem_ctrl.sv
verification/tb_clock_gen.sv
verification/qspi_mem_model.sv
verification/tb_checker.sv
verification/qspi_mem_ctrl_asserts.sv
verification/tb_qspi_mem_ctrl.sv
